// File: all.f
hw/wave_pkg.sv
hw/wave_ram_mem.sv
hw/wave_sequencer.sv
hw/wave_ram_ctrl.sv
hw/wave_ch3_regs.sv
hw/wave_ch3.sv
test/wave_ch3_tb.sv

// File: hw/wave_ch3.sv
`timescale 1ns/1ps
`default_nettype none

module wave_ch3
	import wave_pkg::*;
(
	input  logic       amuk_4mhz,
	input  logic       rst,
	input  logic [7:0] addr,
	input  logic [7:0] wdata,
	input  logic       rd,
	input  logic       wr,
	input  logic       len_tick,
	output logic [7:0] rdata,
	output logic [3:0] sample,
	output logic       ch3_active
);

	logic [10:0]        freq;
	logic [1:0]         vol_code;
	logic               trigger;
	logic [4:0]         pos;
	logic               fetch;
	logic [7:0]         wave_rdata;
	logic [WAVE_AW-1:0] mem_addr;
	logic [7:0]         mem_wdata;
	logic               mem_we;
	logic               mem_re;
	wave_byte_t         mem_rdata;

	wave_ch3_regs i_regs (
		.amuk_4mhz  (amuk_4mhz),
		.rst        (rst),
		.addr       (addr),
		.wdata      (wdata),
		.rd         (rd),
		.wr         (wr),
		.len_tick   (len_tick),
		.wave_rdata (wave_rdata),
		.rdata      (rdata),
		.freq       (freq),
		.vol_code   (vol_code),
		.trigger    (trigger),
		.ch3_active (ch3_active)
	);

	wave_sequencer i_seq (
		.amuk_4mhz  (amuk_4mhz),
		.rst        (rst),
		.freq       (freq),
		.trigger    (trigger),
		.ch3_active (ch3_active),
		.pos        (pos),
		.fetch      (fetch)
	);

	wave_ram_ctrl i_ctrl (
		.amuk_4mhz  (amuk_4mhz),
		.rst        (rst),
		.addr       (addr),
		.wdata      (wdata),
		.rd         (rd),
		.wr         (wr),
		.ch3_active (ch3_active),
		.pos        (pos),
		.fetch      (fetch),
		.vol_code   (vol_code),
		.mem_rdata  (mem_rdata),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_we     (mem_we),
		.mem_re     (mem_re),
		.wave_rdata (wave_rdata),
		.sample     (sample)
	);

	wave_ram_mem i_mem (
		.amuk_4mhz (amuk_4mhz),
		.addr      (mem_addr),
		.wdata     (mem_wdata),
		.we        (mem_we),
		.re        (mem_re),
		.rdata     (mem_rdata)
	);

endmodule

`default_nettype wire

// File: hw/wave_ch3_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wave_ch3_regs
	import wave_pkg::*;
(
	input  logic        amuk_4mhz,
	input  logic        rst,
	input  logic [7:0]  addr,
	input  logic [7:0]  wdata,
	input  logic        rd,
	input  logic        wr,
	input  logic        len_tick,
	input  logic [7:0]  wave_rdata,
	output logic [7:0]  rdata,
	output logic [10:0] freq,
	output logic [1:0]  vol_code,
	output logic        trigger,
	output logic        ch3_active
);

	logic       nr30_wr, nr31_wr, nr32_wr, nr33_wr, nr34_wr;
	logic       dac_en;
	logic       len_en;
	logic [7:0] freq_lo;
	logic [2:0] freq_hi;
	logic [8:0] len_cnt; // 1 to 256 while counting
	logic       trig_req;
	logic       dac_off;
	logic       len_done;
	logic [7:0] rd_val;
	logic [7:0] reg_rdata;

	assign nr30_wr = wr && (addr == ADDR_NR30);
	assign nr31_wr = wr && (addr == ADDR_NR31);
	assign nr32_wr = wr && (addr == ADDR_NR32);
	assign nr33_wr = wr && (addr == ADDR_NR33);
	assign nr34_wr = wr && (addr == ADDR_NR34);

	assign trig_req = nr34_wr && wdata[7] && dac_en; // a trigger with the DAC off does nothing
	assign dac_off  = nr30_wr && !wdata[7];
	assign len_done = len_en && (len_cnt == 9'd0);

	assign freq = {freq_hi, freq_lo};

	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			dac_en   <= 1'b0;
			vol_code <= VOL_MUTE;
			freq_lo  <= '0;
			freq_hi  <= '0;
			len_en   <= 1'b0;
		end else begin
			if (nr30_wr)
				dac_en <= wdata[7];
			if (nr32_wr)
				vol_code <= wdata[6:5];
			if (nr33_wr)
				freq_lo <= wdata;
			if (nr34_wr) begin
				freq_hi <= wdata[2:0];
				len_en  <= wdata[6];
			end
		end
	end

	always_ff @(posedge amuk_4mhz) begin
		if (rst)
			len_cnt <= '0;
		else if (nr31_wr)
			len_cnt <= 9'd256 - {1'b0, wdata};
		else if (trig_req && len_cnt == 9'd0)
			len_cnt <= 9'd256;
		else if (len_tick && len_en && len_cnt != 9'd0)
			len_cnt <= len_cnt - 9'd1;
	end

	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			trigger    <= 1'b0;
			ch3_active <= 1'b0;
		end else begin
			trigger <= trig_req;
			if (dac_off)
				ch3_active <= 1'b0;
			else if (trig_req)
				ch3_active <= 1'b1;
			else if (len_done)
				ch3_active <= 1'b0; // counter reached zero on the previous edge
		end
	end

	// unused and write-only bits read back as ones
	always_comb begin
		case (addr)
			ADDR_NR30: rd_val = {dac_en, 7'h7F};
			ADDR_NR31: rd_val = 8'hFF;
			ADDR_NR32: rd_val = {1'b1, vol_code, 5'h1F};
			ADDR_NR33: rd_val = 8'hFF;
			ADDR_NR34: rd_val = {1'b1, len_en, 6'h3F};
			default:   rd_val = 8'h00;
		endcase
	end

	always_ff @(posedge amuk_4mhz) begin
		if (rst)
			reg_rdata <= '0;
		else if (rd)
			reg_rdata <= rd_val;
	end

	assign rdata = reg_rdata | wave_rdata;

	// a trigger pulse always finds the channel running with the DAC on
	a_trigger_not_killed: assert property (@(posedge amuk_4mhz) disable iff (rst)
		trigger |-> (ch3_active && dac_en));

endmodule

`default_nettype wire

// File: hw/wave_pkg.sv
`default_nettype none

package wave_pkg;

	// wave RAM geometry
	localparam int WAVE_BYTES = 16;
	localparam int WAVE_AW    = 4;

	// low byte of the 0xFFxx register page
	localparam logic [7:0] ADDR_NR30      = 8'h1A;
	localparam logic [7:0] ADDR_NR31      = 8'h1B;
	localparam logic [7:0] ADDR_NR32      = 8'h1C;
	localparam logic [7:0] ADDR_NR33      = 8'h1D;
	localparam logic [7:0] ADDR_NR34      = 8'h1E;
	localparam logic [7:0] ADDR_WAVE_BASE = 8'h30; // wave RAM spans 0x30 to 0x3F

	// NR32 output level codes
	localparam logic [1:0] VOL_MUTE    = 2'd0;
	localparam logic [1:0] VOL_FULL    = 2'd1;
	localparam logic [1:0] VOL_HALF    = 2'd2;
	localparam logic [1:0] VOL_QUARTER = 2'd3;

	// the high nibble is the earlier of the two samples in a byte
	typedef struct packed {
		logic [3:0] hi;
		logic [3:0] lo;
	} wave_nib_t;

	// the CPU sees a byte, playback sees two samples
	typedef union packed {
		logic [7:0] raw;
		wave_nib_t  nib;
	} wave_byte_t;

endpackage

`default_nettype wire

// File: hw/wave_ram_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module wave_ram_ctrl
	import wave_pkg::*;
(
	input  logic               amuk_4mhz,
	input  logic               rst,
	input  logic [7:0]         addr,
	input  logic [7:0]         wdata,
	input  logic               rd,
	input  logic               wr,
	input  logic               ch3_active,
	input  logic [4:0]         pos,
	input  logic               fetch,
	input  logic [1:0]         vol_code,
	input  wave_byte_t         mem_rdata,
	output logic [WAVE_AW-1:0] mem_addr,
	output logic [7:0]         mem_wdata,
	output logic               mem_we,
	output logic               mem_re,
	output logic [7:0]         wave_rdata,
	output logic [3:0]         sample
);

	logic       wave_hit;
	logic       cpu_wr;
	logic       cpu_rd;
	logic       rd_hit_q;   // last CPU read was in wave RAM
	logic       rd_act_q;   // and it happened during playback
	logic [7:0] act_byte_q;
	logic       fetch_q;
	logic       fwd_q;
	logic [7:0] fwd_byte;
	logic       sel_q;
	wave_byte_t sample_byte;
	logic       nib_sel;
	logic [3:0] nibble;

	assign wave_hit = addr[7:WAVE_AW] == ADDR_WAVE_BASE[7:WAVE_AW];
	assign cpu_wr   = wr && wave_hit;
	assign cpu_rd   = rd && wave_hit;

	// playback owns the address while the channel runs
	assign mem_addr  = ch3_active ? pos[4:1] : addr[WAVE_AW-1:0];
	assign mem_wdata = wdata;
	assign mem_we    = cpu_wr;
	// a CPU write wins the port, its data is forwarded into the sample latch instead
	assign mem_re    = ch3_active ? (fetch && !cpu_wr) : cpu_rd;

	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			rd_hit_q <= 1'b0;
			rd_act_q <= 1'b0;
		end else if (rd) begin
			rd_hit_q <= wave_hit;
			rd_act_q <= ch3_active;
		end
	end

	always_ff @(posedge amuk_4mhz) begin
		if (cpu_rd && ch3_active)
			act_byte_q <= sample_byte.raw; // CPU gets the byte being played
	end

	assign wave_rdata = !rd_hit_q ? 8'h00 : (rd_act_q ? act_byte_q : mem_rdata.raw);

	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			fetch_q <= 1'b0;
			fwd_q   <= 1'b0;
		end else begin
			fetch_q <= fetch && ch3_active;
			fwd_q   <= fetch && cpu_wr;
		end
	end

	always_ff @(posedge amuk_4mhz) begin
		fwd_byte <= wdata;
		sel_q    <= pos[0];
	end

	// the fetched byte arrives one cycle after the fetch and is latched here
	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			sample_byte <= '0;
			nib_sel     <= 1'b0;
		end else if (fetch_q) begin
			sample_byte <= fwd_q ? wave_byte_t'(fwd_byte) : mem_rdata;
			nib_sel     <= sel_q;
		end
	end

	assign nibble = nib_sel ? sample_byte.nib.lo : sample_byte.nib.hi;

	always_comb begin
		case (vol_code)
			VOL_MUTE:    sample = 4'h0;
			VOL_FULL:    sample = nibble;
			VOL_HALF:    sample = nibble >> 1;
			VOL_QUARTER: sample = nibble >> 2;
			default:     sample = 4'h0;
		endcase
		if (!ch3_active)
			sample = 4'h0;
	end

	a_mem_one_access: assert property (@(posedge amuk_4mhz) disable iff (rst)
		!(mem_we && mem_re));

endmodule

`default_nettype wire

// File: hw/wave_ram_mem.sv
`timescale 1ns/1ps
`default_nettype none

module wave_ram_mem
	import wave_pkg::*;
(
	input  logic               amuk_4mhz,
	input  logic [WAVE_AW-1:0] addr,
	input  wave_byte_t         wdata,
	input  logic               we,
	input  logic               re,
	output wave_byte_t         rdata
);

	wave_byte_t mem [WAVE_BYTES];

	always_ff @(posedge amuk_4mhz) begin
		if (we)
			mem[addr] <= wdata;
	end

	// output register only moves on a read, so it holds between reads
	always_ff @(posedge amuk_4mhz) begin
		if (re)
			rdata <= mem[addr];
	end

	// one port, so a cycle is either a write or a read
	a_no_rw_collision: assert property (@(posedge amuk_4mhz) !(we && re));

endmodule

`default_nettype wire

// File: hw/wave_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module wave_sequencer
	import wave_pkg::*;
(
	input  logic        amuk_4mhz,
	input  logic        rst,
	input  logic [10:0] freq,
	input  logic        trigger,
	input  logic        ch3_active,
	output logic [4:0]  pos,
	output logic        fetch
);

	logic        div_en; // high on every second cycle to give the 2 MHz step
	logic [10:0] timer;
	logic        step;
	logic        wrap;

	assign step = ch3_active && div_en;
	assign wrap = step && (timer == 11'h7FF);

	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			div_en <= 1'b0;
		end else if (trigger) begin
			div_en <= 1'b0; // restart the divider so the first period is exact
		end else if (ch3_active) begin
			div_en <= !div_en;
		end
	end

	// counts up from freq and reloads on passing 2047
	// 2048 - freq steps of two cycles each make one sample period
	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			timer <= '0;
		end else if (trigger || wrap) begin
			timer <= freq;
		end else if (step) begin
			timer <= timer + 11'd1;
		end
	end

	always_ff @(posedge amuk_4mhz) begin
		if (rst) begin
			pos <= '0;
		end else if (trigger) begin
			pos <= '0;
		end else if (wrap) begin
			pos <= pos + 5'd1; // wraps from 31 back to 0
		end
	end

	// fetch comes with the new pos, so the RAM reads the byte that pos now selects
	always_ff @(posedge amuk_4mhz) begin
		if (rst)
			fetch <= 1'b0;
		else
			fetch <= wrap && !trigger;
	end

	// an idle channel holds its position until the next trigger
	a_pos_frozen: assert property (@(posedge amuk_4mhz) disable iff (rst)
		(!ch3_active && !trigger) |=> $stable(pos));

endmodule

`default_nettype wire

// File: test/wave_ch3_tb.sv
`timescale 1ns/1ps
`default_nettype none

module wave_ch3_tb
	import wave_pkg::*;
();

	localparam int CLK_PERIOD      = 100;
	localparam int DRIVE_DELAY     = 10;
	localparam int SLOW_PERIOD     = 4096; // cycles per sample at freq 0
	localparam int WATCHDOG_CYCLES = 200000;

	logic       amuk_4mhz;
	logic       rst;
	logic [7:0] addr;
	logic [7:0] wdata;
	logic       rd;
	logic       wr;
	logic       len_tick;
	logic [7:0] rdata;
	logic [3:0] sample;
	logic       ch3_active;

	int          errors = 0;
	int          checks = 0;
	int unsigned lcg_state = 99311;

	wave_ch3 i_dut (
		.amuk_4mhz  (amuk_4mhz),
		.rst        (rst),
		.addr       (addr),
		.wdata      (wdata),
		.rd         (rd),
		.wr         (wr),
		.len_tick   (len_tick),
		.rdata      (rdata),
		.sample     (sample),
		.ch3_active (ch3_active)
	);

	initial begin
		amuk_4mhz = 1'b0;
		forever #(CLK_PERIOD / 2) amuk_4mhz = ~amuk_4mhz;
	end

	function automatic logic [7:0] rand_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];
	endfunction

	task automatic next_cycle();
		@(posedge amuk_4mhz);
		#DRIVE_DELAY;
	endtask

	task automatic cpu_write(input logic [7:0] a, input logic [7:0] d);
		addr = a;
		wdata = d;
		wr = 1'b1;
		next_cycle();
		wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [7:0] a, output logic [7:0] d);
		addr = a;
		rd = 1'b1;
		next_cycle();
		rd = 1'b0;
		d = rdata; // registered on the strobe edge
	endtask

	task automatic check_eq(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic wait_sample(input logic [3:0] exp, input int max_cycles);
		int n;
		n = 0;
		while (sample !== exp && n < max_cycles) begin
			next_cycle();
			n++;
		end
		checks++;
		assert (sample === exp) else begin
			errors++;
			$display("sample never reached 0x%0h within %0d cycles", exp, max_cycles);
		end
	endtask

	task automatic pulse_len_tick();
		len_tick = 1'b1;
		next_cycle();
		len_tick = 1'b0;
		next_cycle();
	endtask

	task automatic start_channel(input logic [1:0] vol, input logic [7:0] nr34);
		cpu_write(ADDR_NR30, 8'h80);
		cpu_write(ADDR_NR32, {1'b0, vol, 5'h00});
		cpu_write(ADDR_NR33, 8'h00);
		cpu_write(ADDR_NR34, nr34);
	endtask

	task automatic ram_idle_access();
		logic [7:0] written [WAVE_BYTES];
		logic [7:0] got;
		for (int k = 0; k < WAVE_BYTES; k++) begin
			written[k] = rand_byte();
			cpu_write(ADDR_WAVE_BASE + 8'(k), written[k]);
		end
		for (int k = 0; k < WAVE_BYTES; k++) begin
			cpu_read(ADDR_WAVE_BASE + 8'(k), got);
			check_eq($sformatf("rdata @0x%02h", ADDR_WAVE_BASE + 8'(k)), got, written[k]);
		end
	endtask

	task automatic register_readback();
		logic [7:0] v30;
		logic [7:0] v32;
		logic [7:0] v34;
		logic [7:0] got;
		v30 = rand_byte();
		v32 = rand_byte();
		v34 = rand_byte() & 8'h7F; // bit 7 clear so nothing triggers
		cpu_write(ADDR_NR30, v30);
		cpu_write(ADDR_NR31, rand_byte());
		cpu_write(ADDR_NR32, v32);
		cpu_write(ADDR_NR33, rand_byte());
		cpu_write(ADDR_NR34, v34);
		cpu_read(ADDR_NR30, got);
		check_eq("rdata NR30", got, v30 | 8'h7F);
		cpu_read(ADDR_NR31, got);
		check_eq("rdata NR31", got, 8'hFF);
		cpu_read(ADDR_NR32, got);
		check_eq("rdata NR32", got, v32 | 8'h9F);
		cpu_read(ADDR_NR33, got);
		check_eq("rdata NR33", got, 8'hFF);
		cpu_read(ADDR_NR34, got);
		check_eq("rdata NR34", got, v34 | 8'hBF);
		check_eq("ch3_active", ch3_active, 1'b0);
	endtask

	task automatic playback_order();
		logic [3:0] seen [$];
		logic [3:0] last;
		int n;
		for (int k = 0; k < WAVE_BYTES; k++)
			cpu_write(ADDR_WAVE_BASE + 8'(k), {4'(2 * k), 4'(2 * k + 1)});
		cpu_write(ADDR_NR30, 8'h80);
		cpu_write(ADDR_NR32, {1'b0, VOL_FULL, 5'h00});
		cpu_write(ADDR_NR33, 8'hF0);
		cpu_write(ADDR_NR34, 8'h87); // trigger with freq 0x7F0 so a sample lasts 32 cycles
		check_eq("ch3_active", ch3_active, 1'b1);
		last = sample;
		seen.push_back(last);
		n = 0;
		while (seen.size() < 33 && n < 33 * 40) begin
			next_cycle();
			n++;
			if (sample !== last) begin
				last = sample;
				seen.push_back(last);
			end
		end
		checks++;
		assert (seen.size() == 33) else begin
			errors++;
			$display("playback gave only %0d distinct samples", seen.size());
		end
		foreach (seen[i])
			check_eq($sformatf("sample step %0d", i), seen[i], 8'(i % 16));
		cpu_write(ADDR_NR30, 8'h00);
	endtask

	task automatic volume_levels();
		logic [3:0] exp [4];
		int bad;
		exp = '{4'h0, 4'hA, 4'h5, 4'h2}; // 0xA muted then as is then halved and quartered
		for (int k = 0; k < WAVE_BYTES; k++)
			cpu_write(ADDR_WAVE_BASE + 8'(k), 8'hAA);
		start_channel(VOL_FULL, 8'h80);
		wait_sample(4'hA, 2 * SLOW_PERIOD + 64);
		for (int code = 0; code < 4; code++) begin
			cpu_write(ADDR_NR32, {1'b0, 2'(code), 5'h00});
			check_eq($sformatf("sample vol %0d", code), sample, exp[code]);
			bad = 0;
			repeat (SLOW_PERIOD + 4) begin
				next_cycle();
				if (sample !== exp[code])
					bad++;
			end
			checks++;
			assert (bad == 0) else begin
				errors++;
				$display("sample was not steady at volume code %0d on %0d cycles", code, bad);
			end
		end
		cpu_write(ADDR_NR30, 8'h00);
	endtask

	task automatic length_and_dac_off();
		int n;
		cpu_write(ADDR_NR30, 8'h80);
		cpu_write(ADDR_NR32, {1'b0, VOL_FULL, 5'h00});
		cpu_write(ADDR_NR31, 8'hFC); // four ticks of length
		cpu_write(ADDR_NR34, 8'hC0);
		check_eq("ch3_active after trigger", ch3_active, 1'b1);
		repeat (3) pulse_len_tick();
		check_eq("ch3_active after 3 ticks", ch3_active, 1'b1);
		pulse_len_tick();
		check_eq("ch3_active after 4 ticks", ch3_active, 1'b0);
		check_eq("sample after length end", sample, 4'h0);
		cpu_write(ADDR_NR34, 8'h80);
		check_eq("ch3_active after retrigger", ch3_active, 1'b1);
		cpu_write(ADDR_NR30, 8'h00);
		n = 0;
		while (ch3_active && n < 2) begin
			next_cycle();
			n++;
		end
		check_eq("ch3_active after DAC off", ch3_active, 1'b0);
	endtask

	task automatic playback_access();
		logic [3:0] shown;
		logic [7:0] got;
		for (int k = 0; k < WAVE_BYTES; k++)
			cpu_write(ADDR_WAVE_BASE + 8'(k), 8'(k * 17));
		start_channel(VOL_FULL, 8'h80);
		wait_sample(4'h1, 3 * SLOW_PERIOD + 64); // byte 1 is playing
		shown = sample;
		cpu_read(ADDR_WAVE_BASE, got);
		check_eq("rdata during playback", got, {shown, shown});
		cpu_write(ADDR_WAVE_BASE, 8'h55); // lands on the byte being played
		cpu_write(ADDR_NR30, 8'h00);
		cpu_read(ADDR_WAVE_BASE + 8'(shown), got);
		check_eq("rdata played byte", got, 8'h55);
		cpu_read(ADDR_WAVE_BASE, got);
		check_eq("rdata byte 0", got, 8'h00);
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge amuk_4mhz);
		$display("watchdog expired after %0d cycles and the tests did not finish",
			WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		rst = 1'b1;
		addr = 8'h00;
		wdata = 8'h00;
		rd = 1'b0;
		wr = 1'b0;
		len_tick = 1'b0;
		repeat (8) @(posedge amuk_4mhz);
		#DRIVE_DELAY;
		rst = 1'b0;
		next_cycle();
		ram_idle_access();
		register_readback();
		playback_order();
		volume_levels();
		length_and_dac_off();
		playback_access();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire
